// ==== testbench/fetch_patterns.txt ====
# I <byte address> <instruction word>
# C <allow> <br_taken> <br_target> <excp_flush> <eentry> <ertn_flush> <era>
# allow: 0 stall, 1 ready, 2 random
I 1c000000 02800401
I 1c000004 02800802
I 1c000008 02800c03
I 1c00000c 02801004
I 1c000010 02801405
I 1c000014 02801806
I 1c000018 02801c07
I 1c00001c 02802008
I 1c000020 02802409
I 1c000024 0280280a
I 1c000028 02802c0b
I 1c00002c 0280300c
I 1c000030 0280340d
I 1c000034 0280380e
I 1c000038 02803c0f
I 1c00003c 02804010
# sequential fetch from the reset pc
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
# taken branches forward and back
C 1 1 1c000030 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 1 1c000008 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
# exception entry, return, both at once, flush while stalled
C 1 0 00000000 1 1c000020 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 1 1c000010
C 1 0 00000000 0 00000000 0 00000000
C 1 1 1c000004 1 1c000028 1 1c000018
C 1 0 00000000 0 00000000 0 00000000
C 0 0 00000000 0 00000000 0 00000000
C 0 0 00000000 1 1c000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
# misaligned branch target, held, then flushed to the handler
C 1 1 1c000006 0 00000000 0 00000000
C 0 0 00000000 0 00000000 0 00000000
C 0 0 00000000 0 00000000 0 00000000
C 1 0 00000000 1 1c00001c 0 00000000
C 1 0 00000000 0 00000000 0 00000000
# random back-pressure
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 1 1 1c000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 2 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000
C 1 0 00000000 0 00000000 0 00000000

// ==== verilog.f ====
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/pc_gen.sv
verilog/inst_sram.sv
verilog/fetch_top.sv
testbench/fetch_assert.sv
testbench/tb_fetch.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_fetch
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam addr_t RESET_PC     = 32'h1c00_0000;
    localparam int    SRAM_AW      = 8;
    localparam int    MEM_WORDS    = 1 << SRAM_AW;
    localparam int    RESET_CYCLES = 16;
    localparam int    SLACK_CYCLES = 50;
    localparam int    MAX_ROWS     = 128;
    localparam int    SEED         = 32'h2852081d;
    localparam string PATTERN_FILE = "testbench/fetch_patterns.txt";

    logic   clk;
    logic   reset;
    logic   ds_allowin;
    logic   ds_valid;
    addr_t  ds_pc;
    inst_t  ds_inst;
    logic   ds_excp;
    ecode_t ds_ecode;
    logic   br_taken;
    addr_t  br_target;
    logic   excp_flush;
    addr_t  eentry;
    logic   ertn_flush;
    addr_t  era;
    logic   prog_we;
    addr_t  prog_addr;
    inst_t  prog_wdata;

    // image words written one per reset cycle
    addr_t  img_addr [RESET_CYCLES];
    inst_t  img_data [RESET_CYCLES];
    int     img_count;

    int     row_allow  [MAX_ROWS];
    logic   row_br     [MAX_ROWS];
    addr_t  row_tgt    [MAX_ROWS];
    logic   row_excp   [MAX_ROWS];
    addr_t  row_eentry [MAX_ROWS];
    logic   row_ertn   [MAX_ROWS];
    addr_t  row_era    [MAX_ROWS];
    int     row_count;

    inst_t  ref_mem    [MEM_WORDS];
    logic   ref_loaded [MEM_WORDS];

    // reference model of the fetch stage
    logic   m_valid;
    addr_t  m_pc;
    logic   m_excp;
    logic   held_valid;
    inst_t  held_inst;

    int     cycle_count = 0;
    int     xfer_count;
    int     adef_count;

    fetch_top #(
        .RESET_PC        (RESET_PC),
        .SRAM_ADDR_WIDTH (SRAM_AW)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .ds_allowin (ds_allowin),
        .ds_valid   (ds_valid),
        .ds_pc      (ds_pc),
        .ds_inst    (ds_inst),
        .ds_excp    (ds_excp),
        .ds_ecode   (ds_ecode),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .excp_flush (excp_flush),
        .eentry     (eentry),
        .ertn_flush (ertn_flush),
        .era        (era),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > row_count + RESET_CYCLES + SLACK_CYCLES) begin
            $display("timeout after %0d cycles, pattern rows never finished", cycle_count);
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic int word_index(input addr_t a);
        return int'(a[SRAM_AW+1:2]);
    endfunction

    task automatic load_patterns();
        int    fd;
        int    n;
        int    allow;
        int    br;
        int    ex;
        int    er;
        string line;
        addr_t a0;
        addr_t a1;
        addr_t a2;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            report_problem("cannot open the pattern file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "I") begin
                n = $sscanf(line, "I %h %h", a0, a1);
                if (n != 2 || img_count >= RESET_CYCLES) begin
                    report_problem("malformed or surplus image line in the pattern file");
                end
                img_addr[img_count] = a0;
                img_data[img_count] = a1;
                ref_mem[word_index(a0)] = a1;
                ref_loaded[word_index(a0)] = 1'b1;
                img_count++;
            end else if (n > 0 && line.getc(0) == "C") begin
                n = $sscanf(line, "C %d %d %h %d %h %d %h", allow, br, a0, ex, a1, er, a2);
                if (n != 7 || row_count >= MAX_ROWS) begin
                    report_problem("malformed or surplus cycle row in the pattern file");
                end
                row_allow[row_count]  = allow;
                row_br[row_count]     = (br != 0);
                row_tgt[row_count]    = a0;
                row_excp[row_count]   = (ex != 0);
                row_eentry[row_count] = a1;
                row_ertn[row_count]   = (er != 0);
                row_era[row_count]    = a2;
                row_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_row(input int r);
        logic [31:0] rnd;
        if (row_allow[r] == 2) begin
            rnd = $urandom();
            ds_allowin = rnd[0];
        end else begin
            ds_allowin = (row_allow[r] != 0);
        end
        br_taken   = row_br[r];
        br_target  = row_tgt[r];
        excp_flush = row_excp[r];
        eentry     = row_eentry[r];
        ertn_flush = row_ertn[r];
        era        = row_era[r];
    endtask

    // exception entry, then return, then branch, then sequential
    function automatic addr_t pick_next_pc();
        if (excp_flush) begin
            return eentry;
        end else if (ertn_flush) begin
            return era;
        end else if (br_taken) begin
            return br_target;
        end
        return m_pc + 32'd4;
    endfunction

    task automatic check_and_step();
        logic   flush;
        logic   exp_valid;
        logic   fire;
        ecode_t exp_ecode;
        addr_t  next_pc;
        int     idx;
        flush     = excp_flush | ertn_flush;
        exp_valid = m_valid & (~flush | m_excp);
        fire      = exp_valid & ds_allowin;
        assert (ds_valid === exp_valid)
            else report_mismatch("ds_valid", 32'(exp_valid), 32'(ds_valid));
        if (exp_valid) begin
            exp_ecode = '0;
            exp_ecode[ECODE_ADEF] = m_excp;
            idx = word_index(m_pc);
            assert (ds_pc === m_pc) else report_mismatch("ds_pc", m_pc, ds_pc);
            assert (ds_excp === m_excp)
                else report_mismatch("ds_excp", 32'(m_excp), 32'(ds_excp));
            assert (ds_ecode === exp_ecode)
                else report_mismatch("ds_ecode", 32'(exp_ecode), 32'(ds_ecode));
            if (br_taken) begin
                assert (ds_inst === NOP_INST) else report_mismatch("ds_inst", NOP_INST, ds_inst);
            end else if (ref_loaded[idx]) begin
                assert (ds_inst === ref_mem[idx])
                    else report_mismatch("ds_inst", ref_mem[idx], ds_inst);
            end
            // word must not move while decode holds off
            if (held_valid && !br_taken) begin
                assert (ds_inst === held_inst) else report_mismatch("ds_inst", held_inst, ds_inst);
            end
        end
        held_valid = exp_valid & ~ds_allowin & ~flush & ~br_taken;
        held_inst  = ds_inst;
        if (fire) begin
            xfer_count++;
            if (m_excp) begin
                adef_count++;
            end
        end
        if (~m_valid | fire | flush) begin
            next_pc = pick_next_pc();
            m_pc    = next_pc;
            m_excp  = |next_pc[1:0];
            m_valid = 1'b1;
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        ds_allowin = 1'b0;
        br_taken   = 1'b0;
        br_target  = '0;
        excp_flush = 1'b0;
        eentry     = '0;
        ertn_flush = 1'b0;
        era        = '0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_wdata = '0;
        img_count  = 0;
        row_count  = 0;
        xfer_count = 0;
        adef_count = 0;
        held_valid = 1'b0;
        held_inst  = '0;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_loaded[i] = 1'b0;
        end
        load_patterns();

        // code goes in while the core sits in reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            prog_we = (i < img_count);
            if (i < img_count) begin
                prog_addr  = img_addr[i];
                prog_wdata = img_data[i];
            end
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        reset   = 1'b0;
        m_valid = 1'b0;
        m_pc    = RESET_PC - 32'd4;
        m_excp  = 1'b0;

        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
            @(negedge clk);
            check_and_step();
            @(posedge clk);
            #1;
        end

        if (xfer_count > 0 && adef_count > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("run ended without the expected transfers to decode");
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

// ==== testbench/fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert (
    input logic clk,
    input logic reset,
    input logic ds_allowin,
    input logic excp_flush,
    input logic ertn_flush,
    input logic fetch_en,
    input logic ds_valid
);

    // stage comes out of reset empty
    assert property (@(posedge clk) reset |=> !ds_valid)
        else $error("ds_valid high in the cycle after reset");

    // a held bundle only disappears on a redirect
    assert property (@(posedge clk) disable iff (reset)
        (ds_valid && !ds_allowin) |=> (ds_valid || excp_flush || ertn_flush))
        else $error("stalled bundle dropped without a flush");

    // an accepted fetch shows up one cycle later
    assert property (@(posedge clk) disable iff (reset)
        fetch_en |=> (ds_valid || excp_flush || ertn_flush))
        else $error("accepted fetch did not reach decode one cycle later");

endmodule

bind fetch_ctrl fetch_assert u_fetch_assert (
    .clk        (clk),
    .reset      (reset),
    .ds_allowin (ds_allowin),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush),
    .fetch_en   (fetch_en),
    .ds_valid   (ds_valid)
);

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC        = 32'h1c00_0000,
    parameter int    SRAM_ADDR_WIDTH = 8
) (
    input  logic   clk,
    input  logic   reset,

    // decode handshake
    input  logic   ds_allowin,
    output logic   ds_valid,

    // bundle to decode
    output addr_t  ds_pc,
    output inst_t  ds_inst,
    output logic   ds_excp,
    output ecode_t ds_ecode,

    // branch redirect
    input  logic   br_taken,
    input  addr_t  br_target,

    // exception entry
    input  logic   excp_flush,
    input  addr_t  eentry,

    // exception return
    input  logic   ertn_flush,
    input  addr_t  era,

    // program load into the instruction memory
    input  logic   prog_we,
    input  addr_t  prog_addr,
    input  inst_t  prog_wdata
);

    logic  fs_allowin;
    logic  fetch_en;
    addr_t nextpc;

    fetch_ctrl u_fetch_ctrl (
        .clk        (clk),
        .reset      (reset),
        .ds_allowin (ds_allowin),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .fs_excp    (ds_excp),
        .fs_allowin (fs_allowin),
        .fetch_en   (fetch_en),
        .ds_valid   (ds_valid)
    );

    // held pc and exception go straight to decode
    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .fetch_en   (fetch_en),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .eentry     (eentry),
        .era        (era),
        .nextpc     (nextpc),
        .fs_pc      (ds_pc),
        .fs_excp    (ds_excp),
        .fs_ecode   (ds_ecode)
    );

    inst_sram #(
        .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
    ) u_inst_sram (
        .clk        (clk),
        .fetch_en   (fetch_en),
        .nextpc     (nextpc),
        .br_taken   (br_taken),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .inst       (ds_inst)
    );

endmodule

// ==== verilog/inst_sram.sv ====
`timescale 1ns/1ps

module inst_sram
    import fetch_pkg::*;
#(
    parameter int SRAM_ADDR_WIDTH = 8
) (
    input  logic  clk,

    // read side, driven by the fetch stage
    input  logic  fetch_en,
    input  addr_t nextpc,
    input  logic  br_taken,

    // program load
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  inst_t prog_wdata,

    output inst_t inst
);

    localparam int DEPTH = 1 << SRAM_ADDR_WIDTH;

    typedef logic [SRAM_ADDR_WIDTH-1:0] word_addr_t;

    inst_t      mem [0:DEPTH-1];
    word_addr_t rd_idx;
    word_addr_t wr_idx;
    inst_t      rdata;

    // word index with the byte offset dropped
    assign rd_idx = nextpc[WORD_OFFSET +: SRAM_ADDR_WIDTH];
    assign wr_idx = prog_addr[WORD_OFFSET +: SRAM_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[wr_idx] <= prog_wdata;
        end
    end

    // output register holds while the stage is stalled
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            rdata <= mem[rd_idx];
        end
    end

    // cancelled by a branch resolved this cycle
    assign inst = br_taken ? NOP_INST : rdata;

endmodule

// ==== verilog/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic   clk,
    input  logic   reset,

    // accept strobe from fetch control
    input  logic   fetch_en,

    // branch redirect from execute
    input  logic   br_taken,
    input  addr_t  br_target,

    // exception entry and return
    input  logic   excp_flush,
    input  logic   ertn_flush,
    input  addr_t  eentry,
    input  addr_t  era,

    output addr_t  nextpc,
    output addr_t  fs_pc,
    output logic   fs_excp,
    output ecode_t fs_ecode
);

    addr_t  seq_pc;
    logic   excp_adef;
    ecode_t pfs_ecode;

    assign seq_pc = fs_pc + PC_STEP;

    // exception entry beats return, return beats branch
    always_comb begin
        if (excp_flush) begin
            nextpc = eentry;
        end else if (ertn_flush) begin
            nextpc = era;
        end else if (br_taken) begin
            nextpc = br_target;
        end else begin
            nextpc = seq_pc;
        end
    end

    // misaligned fetch address
    assign excp_adef = |nextpc[WORD_OFFSET-1:0];

    always_comb begin
        pfs_ecode = '0;
        pfs_ecode[ECODE_ADEF] = excp_adef;
    end

    // pc starts one step back so the first request lands on RESET_PC
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc    <= RESET_PC - PC_STEP;
            fs_excp  <= 1'b0;
            fs_ecode <= '0;
        end else if (fetch_en) begin
            fs_pc    <= nextpc;
            fs_excp  <= excp_adef;
            fs_ecode <= pfs_ecode;
        end
    end

endmodule

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic reset,

    // decode side
    input  logic ds_allowin,

    // redirects from the back end
    input  logic excp_flush,
    input  logic ertn_flush,

    // held bundle carries an exception
    input  logic fs_excp,

    output logic fs_allowin,
    output logic fetch_en,
    output logic ds_valid
);

    logic fs_valid;
    logic flush;
    logic to_fs_valid;
    logic fs_ready_go;
    logic ds_fire;

    // either redirect kills whatever sits in the stage
    assign flush = excp_flush | ertn_flush;

    // a new request every cycle once out of reset
    assign to_fs_valid = ~reset;

    // an excepting bundle still goes down so that decode can raise it
    assign fs_ready_go = ~flush | fs_excp;

    assign ds_valid = fs_valid & fs_ready_go;

    // bundle leaves this cycle
    assign ds_fire = ds_valid & ds_allowin;

    // flush forces a fresh entry over the wrong-path one
    assign fs_allowin = ~fs_valid | ds_fire | flush;

    assign fetch_en = to_fs_valid & fs_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= to_fs_valid;
        end
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam int INST_WIDTH  = 32;
    localparam int ECODE_WIDTH = 16;

    // byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // raw instruction word
    typedef logic [INST_WIDTH-1:0] inst_t;

    // one bit per exception source
    typedef logic [ECODE_WIDTH-1:0] ecode_t;

    // position of the fetch address error in ecode_t
    localparam int ECODE_ADEF = 14;

    // low address bits below a word
    localparam int WORD_OFFSET = 2;

    // bytes per instruction
    localparam addr_t PC_STEP = 32'd4;

    // addi.w r0, r0, 0
    localparam inst_t NOP_INST = 32'h0280_0000;

endpackage
